/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_rv_datapath
FILELIST  = rv_datapath.f
BUILD_DIR = obj_dir
PASS_MSG  = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* rv_datapath.f */
+incdir+tests
source/rv_isa_pkg.sv
source/rv_dp_pkg.sv
source/rv_reg_file.sv
source/rv_decode.sv
source/rv_id_ex_reg.sv
source/rv_execute.sv
source/rv_datapath.sv
tests/tb_rv_datapath.sv

/* source/rv_datapath.sv */
`timescale 1ns/1ps

module rv_datapath
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_instr_valid,
    input  rv_isa_pkg::instr_t    i_instr,
    input  rv_dp_pkg::word_t      i_pc,
    output logic                  o_wb_valid,
    output rv_isa_pkg::reg_addr_t o_wb_rd,
    output rv_dp_pkg::word_t      o_wb_data,
    output logic                  o_br_valid,
    output logic                  o_br_taken,
    output rv_dp_pkg::word_t      o_br_target
);

    import rv_isa_pkg::*;
    import rv_dp_pkg::*;

    // decode side bundle
    logic      d_valid, d_reg_write, d_branch;
    alu_op_t   d_alu_op;
    opa_sel_t  d_opa_sel;
    opb_sel_t  d_opb_sel;
    funct3_t   d_funct3;
    reg_addr_t d_rs1, d_rs2, d_rd;
    word_t     d_rs1_data, d_rs2_data, d_imm, d_pc;

    // execute side bundle
    logic      e_valid, e_reg_write, e_branch;
    alu_op_t   e_alu_op;
    opa_sel_t  e_opa_sel;
    opb_sel_t  e_opb_sel;
    funct3_t   e_funct3;
    reg_addr_t e_rs1, e_rs2, e_rd;
    word_t     e_rs1_data, e_rs2_data, e_imm, e_pc;

    // --------------------------------------------------
    // decode, with the register file write port fed back
    // --------------------------------------------------
    rv_decode i_rv_decode
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_wb_we       (o_wb_valid),
        .i_wb_rd       (o_wb_rd),
        .i_wb_data     (o_wb_data),
        .o_valid       (d_valid),
        .o_alu_op      (d_alu_op),
        .o_opa_sel     (d_opa_sel),
        .o_opb_sel     (d_opb_sel),
        .o_reg_write   (d_reg_write),
        .o_branch      (d_branch),
        .o_funct3      (d_funct3),
        .o_rs1         (d_rs1),
        .o_rs2         (d_rs2),
        .o_rd          (d_rd),
        .o_rs1_data    (d_rs1_data),
        .o_rs2_data    (d_rs2_data),
        .o_imm         (d_imm),
        .o_pc          (d_pc)
    );

    rv_id_ex_reg i_rv_id_ex_reg
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (d_valid),
        .i_alu_op    (d_alu_op),
        .i_opa_sel   (d_opa_sel),
        .i_opb_sel   (d_opb_sel),
        .i_reg_write (d_reg_write),
        .i_branch    (d_branch),
        .i_funct3    (d_funct3),
        .i_rs1       (d_rs1),
        .i_rs2       (d_rs2),
        .i_rd        (d_rd),
        .i_rs1_data  (d_rs1_data),
        .i_rs2_data  (d_rs2_data),
        .i_imm       (d_imm),
        .i_pc        (d_pc),
        .o_valid     (e_valid),
        .o_alu_op    (e_alu_op),
        .o_opa_sel   (e_opa_sel),
        .o_opb_sel   (e_opb_sel),
        .o_reg_write (e_reg_write),
        .o_branch    (e_branch),
        .o_funct3    (e_funct3),
        .o_rs1       (e_rs1),
        .o_rs2       (e_rs2),
        .o_rd        (e_rd),
        .o_rs1_data  (e_rs1_data),
        .o_rs2_data  (e_rs2_data),
        .o_imm       (e_imm),
        .o_pc        (e_pc)
    );

    rv_execute i_rv_execute
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (e_valid),
        .i_alu_op    (e_alu_op),
        .i_opa_sel   (e_opa_sel),
        .i_opb_sel   (e_opb_sel),
        .i_reg_write (e_reg_write),
        .i_branch    (e_branch),
        .i_funct3    (e_funct3),
        .i_rs1       (e_rs1),
        .i_rs2       (e_rs2),
        .i_rd        (e_rd),
        .i_rs1_data  (e_rs1_data),
        .i_rs2_data  (e_rs2_data),
        .i_imm       (e_imm),
        .i_pc        (e_pc),
        .o_wb_valid  (o_wb_valid),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data),
        .o_br_valid  (o_br_valid),
        .o_br_taken  (o_br_taken),
        .o_br_target (o_br_target)
    );

endmodule

/* source/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_instr_valid,
    input  rv_isa_pkg::instr_t    i_instr,
    input  rv_dp_pkg::word_t      i_pc,
    input  logic                  i_wb_we,
    input  rv_isa_pkg::reg_addr_t i_wb_rd,
    input  rv_dp_pkg::word_t      i_wb_data,
    output logic                  o_valid,
    output rv_dp_pkg::alu_op_t    o_alu_op,
    output rv_dp_pkg::opa_sel_t   o_opa_sel,
    output rv_dp_pkg::opb_sel_t   o_opb_sel,
    output logic                  o_reg_write,
    output logic                  o_branch,
    output rv_isa_pkg::funct3_t   o_funct3,
    output rv_isa_pkg::reg_addr_t o_rs1,
    output rv_isa_pkg::reg_addr_t o_rs2,
    output rv_isa_pkg::reg_addr_t o_rd,
    output rv_dp_pkg::word_t      o_rs1_data,
    output rv_dp_pkg::word_t      o_rs2_data,
    output rv_dp_pkg::word_t      o_imm,
    output rv_dp_pkg::word_t      o_pc
);

    import rv_isa_pkg::*;
    import rv_dp_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    writes_rd;
    word_t   imm_i;
    word_t   imm_b;
    word_t   imm_u;

    // bit 30 picks sub only for register ops, sra for both
    function automatic alu_op_t alu_from_funct3(input funct3_t f3, input logic b30,
                                                input logic is_reg);
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = (is_reg && b30) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = b30 ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];

    assign o_valid  = i_instr_valid;
    assign o_funct3 = funct3;
    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_rd     = i_instr[11:7];
    assign o_pc     = i_pc;

    // --------------------------------------------------
    // immediates
    // --------------------------------------------------
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};

    rv_reg_file i_rv_reg_file
    (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_rs1 (o_rs1),
        .i_rs2 (o_rs2),
        .i_we  (i_wb_we),
        .i_wa  (i_wb_rd),
        .i_wd  (i_wb_data),
        .o_rd1 (o_rs1_data),
        .o_rd2 (o_rs2_data)
    );

    always_comb
    begin
        o_alu_op  = ALU_ADD;
        o_opa_sel = OPA_RS1;
        o_opb_sel = OPB_RS2;
        o_imm     = '0;
        o_branch  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                writes_rd = 1'b1;
                o_alu_op  = alu_from_funct3(funct3, i_instr[30], 1'b1);
            end
            OPC_OP_IMM:
            begin
                writes_rd = 1'b1;
                o_opb_sel = OPB_IMM;
                o_imm     = imm_i;
                o_alu_op  = alu_from_funct3(funct3, i_instr[30], 1'b0);
            end
            OPC_LUI:
            begin
                writes_rd = 1'b1;
                o_opa_sel = OPA_ZERO;
                o_opb_sel = OPB_IMM;
                o_imm     = imm_u;
            end
            OPC_BRANCH:
            begin
                // rs1 - rs2 gives the equality test, imm feeds the target
                o_branch = 1'b1;
                o_alu_op = ALU_SUB;
                o_imm    = imm_b;
            end
            default:
            begin
                writes_rd = 1'b0;
            end
        endcase
    end

    // unknown opcodes and x0 destinations become bubbles
    assign o_reg_write = writes_rd && (o_rd != '0);

endmodule

/* source/rv_dp_pkg.sv */
package rv_dp_pkg;

    localparam int XLEN    = 32;
    localparam int SHAMT_W = $clog2(XLEN);

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    // --------------------------------------------------
    // alu control
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // operand a is forced to zero for lui
    typedef enum logic {
        OPA_RS1,
        OPA_ZERO
    } opa_sel_t;

    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } opb_sel_t;

endpackage

/* source/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  rv_dp_pkg::alu_op_t    i_alu_op,
    input  rv_dp_pkg::opa_sel_t   i_opa_sel,
    input  rv_dp_pkg::opb_sel_t   i_opb_sel,
    input  logic                  i_reg_write,
    input  logic                  i_branch,
    input  rv_isa_pkg::funct3_t   i_funct3,
    input  rv_isa_pkg::reg_addr_t i_rs1,
    input  rv_isa_pkg::reg_addr_t i_rs2,
    input  rv_isa_pkg::reg_addr_t i_rd,
    input  rv_dp_pkg::word_t      i_rs1_data,
    input  rv_dp_pkg::word_t      i_rs2_data,
    input  rv_dp_pkg::word_t      i_imm,
    input  rv_dp_pkg::word_t      i_pc,
    output logic                  o_wb_valid,
    output rv_isa_pkg::reg_addr_t o_wb_rd,
    output rv_dp_pkg::word_t      o_wb_data,
    output logic                  o_br_valid,
    output logic                  o_br_taken,
    output rv_dp_pkg::word_t      o_br_target
);

    import rv_isa_pkg::*;
    import rv_dp_pkg::*;

    word_t  rs1_val;
    word_t  rs2_val;
    word_t  op_a;
    word_t  op_b;
    word_t  alu_res;
    shamt_t shamt;
    logic   br_taken;
    word_t  br_target;

    // --------------------------------------------------
    // forwarding from the writeback register
    // --------------------------------------------------
    assign rs1_val = (o_wb_valid && (o_wb_rd == i_rs1) && (i_rs1 != '0)) ?
                     o_wb_data : i_rs1_data;
    assign rs2_val = (o_wb_valid && (o_wb_rd == i_rs2) && (i_rs2 != '0)) ?
                     o_wb_data : i_rs2_data;

    assign op_a  = (i_opa_sel == OPA_ZERO) ? '0 : rs1_val;
    assign op_b  = (i_opb_sel == OPB_IMM) ? i_imm : rs2_val;
    assign shamt = op_b[SHAMT_W-1:0];

    // --------------------------------------------------
    // alu
    // --------------------------------------------------
    always_comb
    begin
        case (i_alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            ALU_OR:   alu_res = op_a | op_b;
            default:  alu_res = op_a & op_b;
        endcase
    end

    // equality comes from the alu difference
    always_comb
    begin
        case (i_funct3)
            F3_BEQ:  br_taken = (alu_res == '0);
            F3_BNE:  br_taken = (alu_res != '0);
            F3_BLT:  br_taken = $signed(rs1_val) < $signed(rs2_val);
            F3_BGE:  br_taken = $signed(rs1_val) >= $signed(rs2_val);
            F3_BLTU: br_taken = rs1_val < rs2_val;
            F3_BGEU: br_taken = rs1_val >= rs2_val;
            default: br_taken = 1'b0;
        endcase
    end

    assign br_target = i_pc + i_imm;

    // --------------------------------------------------
    // execute/writeback register
    // --------------------------------------------------
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_wb_valid <= 1'b0;
            o_br_valid <= 1'b0;
        end
        else
        begin
            o_wb_valid <= i_valid && i_reg_write;
            o_br_valid <= i_valid && i_branch;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd     <= i_rd;
        o_wb_data   <= alu_res;
        o_br_taken  <= br_taken;
        o_br_target <= br_target;
    end

    // decode never marks one instruction as both a write and a branch
    a_wb_br_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_wb_valid && o_br_valid));

endmodule

/* source/rv_id_ex_reg.sv */
`timescale 1ns/1ps

module rv_id_ex_reg
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  rv_dp_pkg::alu_op_t    i_alu_op,
    input  rv_dp_pkg::opa_sel_t   i_opa_sel,
    input  rv_dp_pkg::opb_sel_t   i_opb_sel,
    input  logic                  i_reg_write,
    input  logic                  i_branch,
    input  rv_isa_pkg::funct3_t   i_funct3,
    input  rv_isa_pkg::reg_addr_t i_rs1,
    input  rv_isa_pkg::reg_addr_t i_rs2,
    input  rv_isa_pkg::reg_addr_t i_rd,
    input  rv_dp_pkg::word_t      i_rs1_data,
    input  rv_dp_pkg::word_t      i_rs2_data,
    input  rv_dp_pkg::word_t      i_imm,
    input  rv_dp_pkg::word_t      i_pc,
    output logic                  o_valid,
    output rv_dp_pkg::alu_op_t    o_alu_op,
    output rv_dp_pkg::opa_sel_t   o_opa_sel,
    output rv_dp_pkg::opb_sel_t   o_opb_sel,
    output logic                  o_reg_write,
    output logic                  o_branch,
    output rv_isa_pkg::funct3_t   o_funct3,
    output rv_isa_pkg::reg_addr_t o_rs1,
    output rv_isa_pkg::reg_addr_t o_rs2,
    output rv_isa_pkg::reg_addr_t o_rd,
    output rv_dp_pkg::word_t      o_rs1_data,
    output rv_dp_pkg::word_t      o_rs2_data,
    output rv_dp_pkg::word_t      o_imm,
    output rv_dp_pkg::word_t      o_pc
);

    // control bits, gated by valid so an idle slot never writes
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_branch    <= 1'b0;
        end
        else
        begin
            o_valid     <= i_valid;
            o_reg_write <= i_valid && i_reg_write;
            o_branch    <= i_valid && i_branch;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_alu_op   <= i_alu_op;
        o_opa_sel  <= i_opa_sel;
        o_opb_sel  <= i_opb_sel;
        o_funct3   <= i_funct3;
        o_rs1      <= i_rs1;
        o_rs2      <= i_rs2;
        o_rd       <= i_rd;
        o_rs1_data <= i_rs1_data;
        o_rs2_data <= i_rs2_data;
        o_imm      <= i_imm;
        o_pc       <= i_pc;
    end

    // the caller's strobe must be driven cleanly once out of reset
    a_valid_known: assert property (@(posedge i_clk) disable iff (i_rst)
        !$isunknown(o_valid));

endmodule

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int NUM_REGS = 32;

    typedef logic [31:0]                   instr_t;
    typedef logic [$clog2(NUM_REGS)-1:0]   reg_addr_t;
    typedef logic [6:0]                    opcode_t;
    typedef logic [2:0]                    funct3_t;

    // --------------------------------------------------
    // major opcodes handled by this slice
    // --------------------------------------------------
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // register and immediate alu ops
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // conditional branches, 010 and 011 are not defined
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

endpackage

/* source/rv_reg_file.sv */
`timescale 1ns/1ps

module rv_reg_file
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  rv_isa_pkg::reg_addr_t i_rs1,
    input  rv_isa_pkg::reg_addr_t i_rs2,
    input  logic                  i_we,
    input  rv_isa_pkg::reg_addr_t i_wa,
    input  rv_dp_pkg::word_t      i_wd,
    output rv_dp_pkg::word_t      o_rd1,
    output rv_dp_pkg::word_t      o_rd2
);

    import rv_isa_pkg::*;
    import rv_dp_pkg::*;

    // no storage behind x0
    word_t regs [1:NUM_REGS-1];

    // x0 reads zero, a write in flight is seen at once
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0)
            data = '0;
        else if (i_we && (i_wa == addr))
            data = i_wd;
        else
            data = regs[addr];
        return data;
    endfunction

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            for (int i = 1; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_wa != '0))
        begin
            regs[i_wa] <= i_wd;
        end
    end

    always_comb
    begin
        o_rd1 = read_port(i_rs1);
        o_rd2 = read_port(i_rs2);
    end

    // decode drops rd == x0, so no write may ever target it
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_we && (i_wa == '0)));

endmodule

/* tests/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// --------------------------------------------------
// random source
// --------------------------------------------------
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// --------------------------------------------------
// instruction encoders
// --------------------------------------------------
function automatic instr_t encode_r(input logic [6:0] funct7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input funct3_t f3,
                                    input reg_addr_t rd);
    return {funct7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic instr_t encode_i(input logic [11:0] imm12, input reg_addr_t rs1,
                                    input funct3_t f3, input reg_addr_t rd);
    return {imm12, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic instr_t encode_u(input logic [19:0] imm20, input reg_addr_t rd);
    return {imm20, rd, OPC_LUI};
endfunction

// bit 0 of the offset is implied zero
function automatic instr_t encode_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input funct3_t f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic word_t sext13(input logic [12:0] v);
    return {{19{v[12]}}, v};
endfunction

// --------------------------------------------------
// architectural semantics
// --------------------------------------------------
// alt mirrors funct7 bit 5 and picks sub or sra
function automatic word_t alu_result(input funct3_t f3, input logic alt,
                                     input word_t a, input word_t b);
    logic signed [31:0] sa;
    word_t              res;
    sa = a;
    case (f3)
        F3_ADD_SUB: res = alt ? (a - b) : (a + b);
        F3_SLL:     res = a << b[4:0];
        F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
        F3_XOR:     res = a ^ b;
        F3_SRL_SRA:
        begin
            if (alt)
                res = sa >>> b[4:0];
            else
                res = a >> b[4:0];
        end
        F3_OR:      res = a | b;
        default:    res = a & b;
    endcase
    return res;
endfunction

function automatic logic branch_taken(input funct3_t f3, input word_t a, input word_t b);
    logic t;
    case (f3)
        F3_BEQ:  t = (a == b);
        F3_BNE:  t = (a != b);
        F3_BLT:  t = ($signed(a) < $signed(b));
        F3_BGE:  t = ($signed(a) >= $signed(b));
        F3_BLTU: t = (a < b);
        F3_BGEU: t = (a >= b);
        default: t = 1'b0;
    endcase
    return t;
endfunction

`endif

/* tests/tb_rv_datapath.sv */
`timescale 1ns/1ps

module tb_rv_datapath;

    import rv_isa_pkg::*;
    import rv_dp_pkg::*;

    localparam int      NUM_SLOTS   = 2200;
    localparam int      DRAIN_LIMIT = 20;
    localparam opcode_t OPC_CUSTOM0 = 7'b0001011;

    typedef struct packed {
        logic        is_branch;
        reg_addr_t   rd;
        word_t       data;
        logic        taken;
        word_t       target;
        logic [31:0] due;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    instr_t      instr;
    word_t       pc;
    logic        wb_valid;
    reg_addr_t   wb_rd;
    word_t       wb_data;
    logic        br_valid;
    logic        br_taken;
    word_t       br_target;

    logic [31:0] rng_state;
    logic [31:0] neg_cnt;
    word_t       next_pc;
    word_t       model_regs [0:NUM_REGS-1];
    expect_t     exp_q [$];
    logic        drained;

    `include "rv_ref_model.svh"

    rv_datapath i_rv_datapath
    (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .i_pc          (pc),
        .o_wb_valid    (wb_valid),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data),
        .o_br_valid    (br_valid),
        .o_br_taken    (br_taken),
        .o_br_target   (br_target)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] draw_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t model_read(input reg_addr_t a);
        return (a == '0) ? '0 : model_regs[a];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            abort_run($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
                                $time, name, expected, actual));
        end
    endtask

    // --------------------------------------------------
    // stimulus with one slot per clock
    // --------------------------------------------------
    task automatic issue_slot();
        logic [31:0] r;
        logic [31:0] f;
        logic [31:0] sel;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        funct3_t     f3;
        opcode_t     opc;
        logic        alt;
        logic        writes;
        logic [11:0] imm12;
        logic [12:0] off;
        word_t       res;
        instr_t      ins;
        expect_t     e;

        r      = draw_random();
        f      = draw_random();
        sel    = draw_random() % 32'd10;
        rs1    = {2'b00, r[2:0]};
        rs2    = {2'b00, r[5:3]};
        rd     = {2'b00, r[8:6]};
        f3     = r[11:9];
        alt    = 1'b0;
        writes = 1'b0;
        res    = '0;
        e      = '0;

        if ((draw_random() % 32'd10) == 32'd0)
        begin
            // idle slot carries junk that must be ignored
            instr_valid <= 1'b0;
            instr       <= f;
            pc          <= next_pc;
        end
        else
        begin
            if (sel == 32'd0)
            begin
                opc = f[6:0];
                if ((opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_LUI) ||
                    (opc == OPC_BRANCH))
                    opc = OPC_CUSTOM0;
                ins = {f[31:7], opc};
            end
            else if (sel <= 32'd3)
            begin
                alt    = r[12] && ((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA));
                ins    = encode_r(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd);
                res    = alu_result(f3, alt, model_read(rs1), model_read(rs2));
                writes = 1'b1;
            end
            else if (sel <= 32'd6)
            begin
                if (f3 == F3_SLL)
                    imm12 = {7'b0000000, f[4:0]};
                else if (f3 == F3_SRL_SRA)
                begin
                    alt   = r[12];
                    imm12 = {1'b0, alt, 5'b00000, f[4:0]};
                end
                else
                    imm12 = f[11:0];
                ins    = encode_i(imm12, rs1, f3, rd);
                res    = alu_result(f3, alt, model_read(rs1), sext12(imm12));
                writes = 1'b1;
            end
            else if (sel == 32'd7)
            begin
                ins    = encode_u(f[19:0], rd);
                res    = {f[19:0], 12'h000};
                writes = 1'b1;
            end
            else
            begin
                // fold the undefined 010 and 011 onto bltu and bgeu
                if ((f3 == 3'b010) || (f3 == 3'b011))
                    f3[2] = 1'b1;
                off         = {f[12:1], 1'b0};
                ins         = encode_b(off, rs2, rs1, f3);
                e.is_branch = 1'b1;
                e.taken     = branch_taken(f3, model_read(rs1), model_read(rs2));
                e.target    = next_pc + sext13(off);
            end

            if (writes && (rd != '0))
            begin
                model_regs[rd] = res;
                e.rd           = rd;
                e.data         = res;
            end

            // sampled at the next edge and visible three negedges from now
            if (e.is_branch || (writes && (rd != '0)))
            begin
                e.due = neg_cnt + 32'd3;
                exp_q.push_back(e);
            end

            instr_valid <= 1'b1;
            instr       <= ins;
            pc          <= next_pc;
            next_pc     = next_pc + 32'd4;
        end
    endtask

    // --------------------------------------------------
    // output checking on the falling edge
    // --------------------------------------------------
    task automatic check_outputs();
        expect_t e;
        if ((exp_q.size() > 0) && (exp_q[0].due == neg_cnt))
        begin
            e = exp_q.pop_front();
            compare("o_wb_valid", word_t'(!e.is_branch), word_t'(wb_valid));
            compare("o_br_valid", word_t'(e.is_branch), word_t'(br_valid));
            if (e.is_branch)
            begin
                compare("o_br_taken", word_t'(e.taken), word_t'(br_taken));
                compare("o_br_target", e.target, br_target);
            end
            else
            begin
                compare("o_wb_rd", word_t'(e.rd), word_t'(wb_rd));
                compare("o_wb_data", e.data, wb_data);
            end
        end
        else if ((wb_valid !== 1'b0) || (br_valid !== 1'b0))
        begin
            abort_run($sformatf("an output strobe appeared at %0t with no result due", $time));
        end
    endtask

    always @(negedge clk)
    begin
        neg_cnt = neg_cnt + 32'd1;
        if (!rst)
            check_outputs();
    end

    task automatic wait_for_drain(output logic done);
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0) && (cycles < DRAIN_LIMIT))
        begin
            @(posedge clk);
            cycles++;
        end
        done = (exp_q.size() == 0);
    endtask

    initial
    begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rng_state   = 32'd71812;
        neg_cnt     = 32'd0;
        next_pc     = 32'h0000_1000;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            model_regs[i] = '0;
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int n = 0; n < NUM_SLOTS; n++)
        begin
            @(posedge clk);
            issue_slot();
        end
        @(posedge clk);
        instr_valid <= 1'b0;

        wait_for_drain(drained);
        if (drained)
        begin
            // a few quiet cycles catch any late strobe
            repeat (4) @(posedge clk);
            $display("Verification passed");
            $finish;
        end
        else
        begin
            abort_run("timed out waiting for the last results to come out");
        end
    end

endmodule
